// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		--top-module dualIssueCtrl_tb -f sim.f -o simv
	./obj_dir/simv

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		--top-module dualIssueCtrl_tb -f sim.f

clean:
	rm -rf obj_dir

// File: ctrlPipe.sv
//////////////////////////////////////////////////
// execute, memory and writeback control registers
// of one slot, with branch resolution in execute
//////////////////////////////////////////////////
`default_nettype none

module ctrlPipe (
   input  logic                clk,
   input  logic                reset,
   input  logic                flushE_i,
   input  ctrl_pkg::decCtrlT   ctrlD_i,
   input  ctrl_pkg::decInstrT  instrD_i,
   input  logic                zeroE_i,
   output logic                pcSrcE_o,
   output ctrl_pkg::aluCtrlE   aluControlE_o,
   output logic                aluSrcE_o,
   output ctrl_pkg::stageRegsT regsE_o,
   output logic                loadE_o,
   output ctrl_pkg::wbInfoT    memWbM_o,
   output logic                memWriteM_o,
   output ctrl_pkg::resultSrcE resultSrcM_o,
   output ctrl_pkg::wbInfoT    wbInfoW_o,
   output ctrl_pkg::resultSrcE resultSrcW_o
);

   import ctrl_pkg::*;

   logic      regWriteE;
   logic      memWriteE;
   logic      branchE;
   logic      branchNeE;
   logic      jumpE;
   resultSrcE resSrcE;
   stageRegsT regsE;
   wbInfoT    wbM;
   wbInfoT    wbW;

   // execute stage, a flush turns it into a bubble
   always_ff @(posedge clk) begin
      if (reset || flushE_i) begin
         regWriteE     <= 1'b0;
         memWriteE     <= 1'b0;
         branchE       <= 1'b0;
         branchNeE     <= 1'b0;
         jumpE         <= 1'b0;
         resSrcE       <= resAlu;
         aluControlE_o <= aluAdd;
         aluSrcE_o     <= 1'b0;
         regsE         <= '0;
      end else begin
         regWriteE     <= ctrlD_i.regWrite;
         memWriteE     <= ctrlD_i.memWrite;
         branchE       <= ctrlD_i.branch;
         branchNeE     <= ctrlD_i.branchNe;
         jumpE         <= ctrlD_i.jump;
         resSrcE       <= ctrlD_i.resultSrc;
         aluControlE_o <= ctrlD_i.aluControl;
         aluSrcE_o     <= ctrlD_i.aluSrc;
         regsE.rs1     <= instrD_i.rs1;
         regsE.rs2     <= instrD_i.rs2;
         regsE.rd      <= instrD_i.rd;
      end
   end

   // memory and writeback never stall or flush
   always_ff @(posedge clk) begin
      if (reset) begin
         wbM          <= '0;
         memWriteM_o  <= 1'b0;
         resultSrcM_o <= resAlu;
         wbW          <= '0;
         resultSrcW_o <= resAlu;
      end else begin
         wbM          <= '{regWrite: regWriteE, rd: regsE.rd};
         memWriteM_o  <= memWriteE;
         resultSrcM_o <= resSrcE;
         wbW          <= wbM;
         resultSrcW_o <= resultSrcM_o;
      end
   end

   // taken when beq sees zero, bne sees nonzero, or any jump
   assign pcSrcE_o  = (branchE && (zeroE_i ^ branchNeE)) || jumpE;
   assign loadE_o   = (resSrcE == resLoad);
   assign regsE_o   = regsE;
   assign memWbM_o  = wbM;
   assign wbInfoW_o = wbW;

endmodule

`default_nettype wire

// File: ctrl_defines.svh
//////////////////////////////////////////////////
// dual-issue controller widths and encodings
// funct3 codes used by the ALU and branch decode
//////////////////////////////////////////////////
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// register file addressing
`define REG_ADDR_W 5

// instruction field widths
`define OPCODE_W   7
`define FUNCT3_W   3

// x0 is hardwired, never a hazard or forward source
`define ZERO_REG   0

// funct3 of the ALU operations
`define F3_ADDSUB  3'b000
`define F3_SLT     3'b010
`define F3_OR      3'b110
`define F3_AND     3'b111

// funct3 of bne, beq is 3'b000
`define F3_BNE     3'b001

`endif

// File: ctrl_golden.txt
# op1 f3 f7 rs1 rs2 rd | op2 f3 f7 rs1 rs2 rd | zero1 zero2 mispredict | slot1 slot2 | raw waw
# all hex, slot digits: stallF stallD flushD immSrc pcSrc aluCtl aluSrc fwdA fwdB memW resM regW resW
00 0 0 0 0 0  00 0 0 0 0 0  0 0 0  0000000000000 0000000000000 0 0
03 2 0 1 0 5  00 0 0 0 0 0  0 0 0  0000000000000 0000000000000 0 0
33 0 0 5 2 6  00 0 0 0 0 0  0 0 0  1100001000000 0000000000000 0 0
33 0 0 5 2 6  00 0 0 0 0 0  0 0 0  0000000000100 0000000000000 0 0
33 0 1 6 5 7  00 0 0 0 0 0  0 0 0  0000000100011 0000000000000 0 0
33 6 0 7 6 8  00 0 0 0 0 0  0 0 0  0000010200000 0000000000000 0 0
33 7 0 8 7 9  00 0 0 0 0 0  0 0 0  0000030210010 0000000000000 0 0
33 2 0 9 8 a  00 0 0 0 0 0  0 0 0  0000020210010 0000000000000 0 0
13 0 1 0 0 b  23 2 0 0 a 0  0 0 0  0000050210010 0001000000000 0 0
00 0 0 0 0 0  00 0 0 0 0 0  0 0 0  0000001000010 0000001060000 0 0
00 0 0 0 0 0  33 0 0 b 0 c  0 0 0  0000000000010 0000000001000 0 0
00 0 0 0 0 0  00 0 0 0 0 0  0 0 0  0000000000010 0000000500000 0 0
63 0 0 1 2 0  63 1 0 3 4 0  0 0 0  0002000000000 0002000000000 0 0
00 0 0 0 0 0  00 0 0 0 0 0  1 1 0  0000110000000 0000010000010 0 0
63 0 0 1 2 0  63 1 0 3 4 0  0 0 0  0002000000000 0002000000000 0 0
6f 0 0 0 0 1  67 0 0 5 0 0  0 0 0  0003010000000 0000110000000 0 0
00 0 0 0 0 0  00 0 0 0 0 0  0 0 0  0000100000000 0000101000000 0 0
37 0 0 0 0 d  33 0 0 d 0 e  0 0 0  0004000000200 0010000000200 1 0
13 0 0 0 0 f  37 0 0 0 0 f  0 0 0  0000000000012 0014000000012 0 1
13 0 0 0 0 10 13 0 0 0 10 11 0 0 0 0000001000300 0000000000000 0 0
13 0 0 0 0 10 23 2 0 0 10 0  0 0 0 0000001000013 0011001000000 1 0
03 2 0 0 0 12 00 0 0 0 0 0  0 0 0  0000001000010 0000000000000 0 0
00 0 0 0 0 0  33 0 0 12 0 13 0 0 0 0000001000010 0010000000010 0 0
33 0 0 1 2 14 33 0 0 3 4 15 0 0 1  0010000000110 0010000000000 0 0
00 0 0 0 0 0  00 0 0 0 0 0  0 0 0  0000000000011 0000000000000 0 0
00 0 0 0 0 0  00 0 0 0 0 0  0 0 0  0000000000000 0000000000000 0 0
00 0 0 0 0 0  00 0 0 0 0 0  0 0 0  0000000000000 0000000000000 0 0

// File: ctrl_pkg.sv
//////////////////////////////////////////////////
// shared types of the dual-issue controller
// opcodes, control encodings and stage bundles
//////////////////////////////////////////////////
`default_nettype none

`include "ctrl_defines.svh"

package ctrl_pkg;

   // RV32I major opcodes handled by the decoder
   typedef enum logic [`OPCODE_W-1:0] {
      opLw       = 7'b0000011,
      opSw       = 7'b0100011,
      opRtype    = 7'b0110011,
      opBranch   = 7'b1100011,
      opItypeAlu = 7'b0010011,
      opJal      = 7'b1101111,
      opLui      = 7'b0110111,
      opJalr     = 7'b1100111
   } opcodeE;

   typedef enum logic [2:0] {
      aluAdd = 3'b000,
      aluSub = 3'b001,
      aluAnd = 3'b010,
      aluOr  = 3'b011,
      aluSlt = 3'b101
   } aluCtrlE;

   typedef enum logic [1:0] {
      aluOpMem    = 2'b00,
      aluOpBranch = 2'b01,
      aluOpOther  = 2'b10
   } aluOpE;

   typedef enum logic [2:0] {
      immI = 3'b000,
      immS = 3'b001,
      immB = 3'b010,
      immJ = 3'b011,
      immU = 3'b100
   } immSrcE;

   typedef enum logic [1:0] {
      resAlu     = 2'b00,
      resLoad    = 2'b01,
      resPcPlus4 = 2'b10,
      resImm     = 2'b11
   } resultSrcE;

   // none selects the register file value
   typedef enum logic [1:0] {
      fwdNone = 2'b00,
      fwdWb   = 2'b01,
      fwdMem  = 2'b10
   } fwdSrcE;

   typedef struct packed {
      logic   crossSlot;
      fwdSrcE src;
   } fwdSelT;

   typedef logic [`REG_ADDR_W-1:0] regAddrT;

   // fields of one instruction sitting in decode
   typedef struct packed {
      opcodeE                op;
      logic [`FUNCT3_W-1:0]  funct3;
      logic                  funct7b5;
      regAddrT               rs1;
      regAddrT               rs2;
      regAddrT               rd;
   } decInstrT;

   typedef struct packed {
      logic      regWrite;
      immSrcE    immSrc;
      logic      aluSrc;
      logic      memWrite;
      resultSrcE resultSrc;
      logic      branch;
      logic      branchNe;
      logic      jump;
      aluCtrlE   aluControl;
   } decCtrlT;

   typedef struct packed {
      regAddrT rs1;
      regAddrT rs2;
      regAddrT rd;
   } stageRegsT;

   // everything one slot reports to the datapath
   typedef struct packed {
      logic      stallF;
      logic      stallD;
      logic      flushD;
      immSrcE    immSrcD;
      logic      pcSrcE;
      aluCtrlE   aluControlE;
      logic      aluSrcE;
      fwdSelT    forwardAE;
      fwdSelT    forwardBE;
      logic      memWriteM;
      resultSrcE resultSrcM;
      logic      regWriteW;
      resultSrcE resultSrcW;
   } slotOutT;

   // write port of a later stage, seen by forwarding
   typedef struct packed {
      logic    regWrite;
      regAddrT rd;
   } wbInfoT;

endpackage

`default_nettype wire

// File: dualIssueCtrl.sv
//////////////////////////////////////////////////
// two-slot in-order RISC-V pipeline controller
// per-slot decode, pipeline and forwarding plus
// one shared hazard unit
//////////////////////////////////////////////////
`default_nettype none

module dualIssueCtrl (
   input  logic               clk,
   input  logic               reset,
   input  ctrl_pkg::decInstrT instr1D_i,
   input  ctrl_pkg::decInstrT instr2D_i,
   input  logic               zero1E_i,
   input  logic               zero2E_i,
   input  logic               mispredict_i,
   output ctrl_pkg::slotOutT  slot1_o,
   output ctrl_pkg::slotOutT  slot2_o,
   output logic               raw_o,
   output logic               waw_o
);

   import ctrl_pkg::*;

   decCtrlT   ctrl1D;
   decCtrlT   ctrl2D;
   stageRegsT regs1E;
   stageRegsT regs2E;
   logic      load1E;
   logic      load2E;
   wbInfoT    wbM1;
   wbInfoT    wbW1;
   wbInfoT    wbM2;
   wbInfoT    wbW2;
   logic      flushE1;
   logic      flushE2;
   logic      stall1;
   logic      stall2;

   instrDecoder i_dec1 (.instr_i(instr1D_i), .ctrl_o(ctrl1D));
   instrDecoder i_dec2 (.instr_i(instr2D_i), .ctrl_o(ctrl2D));

   ctrlPipe i_pipe1 (
      .clk(clk), .reset(reset), .flushE_i(flushE1), .ctrlD_i(ctrl1D),
      .instrD_i(instr1D_i), .zeroE_i(zero1E_i), .pcSrcE_o(slot1_o.pcSrcE),
      .aluControlE_o(slot1_o.aluControlE), .aluSrcE_o(slot1_o.aluSrcE),
      .regsE_o(regs1E), .loadE_o(load1E), .memWbM_o(wbM1),
      .memWriteM_o(slot1_o.memWriteM), .resultSrcM_o(slot1_o.resultSrcM),
      .wbInfoW_o(wbW1), .resultSrcW_o(slot1_o.resultSrcW)
   );

   ctrlPipe i_pipe2 (
      .clk(clk), .reset(reset), .flushE_i(flushE2), .ctrlD_i(ctrl2D),
      .instrD_i(instr2D_i), .zeroE_i(zero2E_i), .pcSrcE_o(slot2_o.pcSrcE),
      .aluControlE_o(slot2_o.aluControlE), .aluSrcE_o(slot2_o.aluSrcE),
      .regsE_o(regs2E), .loadE_o(load2E), .memWbM_o(wbM2),
      .memWriteM_o(slot2_o.memWriteM), .resultSrcM_o(slot2_o.resultSrcM),
      .wbInfoW_o(wbW2), .resultSrcW_o(slot2_o.resultSrcW)
   );

   // own and other swapped between the two slots
   forwardUnit i_fwd1 (
      .regsE_i(regs1E), .ownM_i(wbM1), .ownW_i(wbW1), .otherM_i(wbM2),
      .otherW_i(wbW2), .forwardA_o(slot1_o.forwardAE), .forwardB_o(slot1_o.forwardBE)
   );

   forwardUnit i_fwd2 (
      .regsE_i(regs2E), .ownM_i(wbM2), .ownW_i(wbW2), .otherM_i(wbM1),
      .otherW_i(wbW1), .forwardA_o(slot2_o.forwardAE), .forwardB_o(slot2_o.forwardBE)
   );

   hazardUnit i_hazard (
      .instr1D_i(instr1D_i), .instr2D_i(instr2D_i), .regWrite1D_i(ctrl1D.regWrite),
      .regWrite2D_i(ctrl2D.regWrite), .regs1E_i(regs1E), .regs2E_i(regs2E),
      .load1E_i(load1E), .load2E_i(load2E), .mispredict_i(mispredict_i),
      .stall1_o(stall1), .stall2_o(stall2), .flushD1_o(slot1_o.flushD),
      .flushD2_o(slot2_o.flushD), .flushE1_o(flushE1), .flushE2_o(flushE2),
      .raw_o(raw_o), .waw_o(waw_o)
   );

   // fetch and decode stall together
   assign slot1_o.stallF    = stall1;
   assign slot1_o.stallD    = stall1;
   assign slot2_o.stallF    = stall2;
   assign slot2_o.stallD    = stall2;
   assign slot1_o.immSrcD   = ctrl1D.immSrc;
   assign slot2_o.immSrcD   = ctrl2D.immSrc;
   assign slot1_o.regWriteW = wbW1.regWrite;
   assign slot2_o.regWriteW = wbW2.regWrite;

endmodule

`default_nettype wire

// File: dualIssueCtrl_tb.sv
//////////////////////////////////////////////////
// testbench for the dual-issue controller
// replays golden vectors and checks every output
//////////////////////////////////////////////////
`default_nettype none

module dualIssueCtrl_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import ctrl_pkg::*;

   // one golden line, inputs then expected outputs
   typedef struct packed {
      decInstrT instr1;
      decInstrT instr2;
      logic     zero1;
      logic     zero2;
      logic     mispredict;
      slotOutT  exp1;
      slotOutT  exp2;
      logic     raw;
      logic     waw;
   } vectorT;

   logic     clk;
   logic     reset;
   decInstrT instr1D;
   decInstrT instr2D;
   logic     zero1E;
   logic     zero2E;
   logic     mispredict;
   slotOutT  slot1;
   slotOutT  slot2;
   logic     raw;
   logic     waw;

   vectorT   vectors[$];
   int       numVectors = 0;

   dualIssueCtrl i_dualIssueCtrl (
      .clk(clk), .reset(reset), .instr1D_i(instr1D), .instr2D_i(instr2D),
      .zero1E_i(zero1E), .zero2E_i(zero2E), .mispredict_i(mispredict),
      .slot1_o(slot1), .slot2_o(slot2), .raw_o(raw), .waw_o(waw)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic failRun(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                 input logic [31:0] actVal);
      failRun($sformatf("CHECK FAILED %s expected 0x%0h actual 0x%0h",
                        name, expVal, actVal));
   endtask

   task automatic checkBit(input string name, input logic expVal, input logic actVal);
      if (actVal !== expVal) begin
         reportMismatch(name, 32'(expVal), 32'(actVal));
      end
   endtask

   task automatic checkFwd(input string name, input fwdSelT expVal, input fwdSelT actVal);
      if (actVal !== expVal) begin
         reportMismatch(name, 32'(expVal), 32'(actVal));
      end
   endtask

   task automatic checkSlot(input string name, input slotOutT expVal, input slotOutT actVal);
      checkBit({name, ".stallF"}, expVal.stallF, actVal.stallF);
      checkBit({name, ".stallD"}, expVal.stallD, actVal.stallD);
      checkBit({name, ".flushD"}, expVal.flushD, actVal.flushD);
      if (actVal.immSrcD !== expVal.immSrcD) begin
         reportMismatch({name, ".immSrcD"}, 32'(expVal.immSrcD), 32'(actVal.immSrcD));
      end
      checkBit({name, ".pcSrcE"}, expVal.pcSrcE, actVal.pcSrcE);
      if (actVal.aluControlE !== expVal.aluControlE) begin
         reportMismatch({name, ".aluControlE"}, 32'(expVal.aluControlE),
                        32'(actVal.aluControlE));
      end
      checkBit({name, ".aluSrcE"}, expVal.aluSrcE, actVal.aluSrcE);
      checkFwd({name, ".forwardAE"}, expVal.forwardAE, actVal.forwardAE);
      checkFwd({name, ".forwardBE"}, expVal.forwardBE, actVal.forwardBE);
      checkBit({name, ".memWriteM"}, expVal.memWriteM, actVal.memWriteM);
      if (actVal.resultSrcM !== expVal.resultSrcM) begin
         reportMismatch({name, ".resultSrcM"}, 32'(expVal.resultSrcM),
                        32'(actVal.resultSrcM));
      end
      checkBit({name, ".regWriteW"}, expVal.regWriteW, actVal.regWriteW);
      if (actVal.resultSrcW !== expVal.resultSrcW) begin
         reportMismatch({name, ".resultSrcW"}, 32'(expVal.resultSrcW),
                        32'(actVal.resultSrcW));
      end
   endtask

   function automatic decInstrT makeInstr(input logic [51:0] op, input logic [51:0] f3,
                                          input logic [51:0] f7, input logic [51:0] rs1,
                                          input logic [51:0] rs2, input logic [51:0] rd);
      decInstrT d;
      d.op       = opcodeE'(op[6:0]);
      d.funct3   = f3[2:0];
      d.funct7b5 = f7[0];
      d.rs1      = rs1[4:0];
      d.rs2      = rs2[4:0];
      d.rd       = rd[4:0];
      return d;
   endfunction

   // one hex digit per output field, stallF in the top digit
   function automatic slotOutT expandDigits(input logic [51:0] n);
      slotOutT s;
      s.stallF      = n[48];
      s.stallD      = n[44];
      s.flushD      = n[40];
      s.immSrcD     = immSrcE'(n[38:36]);
      s.pcSrcE      = n[32];
      s.aluControlE = aluCtrlE'(n[30:28]);
      s.aluSrcE     = n[24];
      s.forwardAE   = fwdSelT'(n[22:20]);
      s.forwardBE   = fwdSelT'(n[18:16]);
      s.memWriteM   = n[12];
      s.resultSrcM  = resultSrcE'(n[9:8]);
      s.regWriteW   = n[4];
      s.resultSrcW  = resultSrcE'(n[1:0]);
      return s;
   endfunction

   task automatic loadVectors();
      int          fd;
      int          got;
      string       line;
      logic [51:0] col [0:18];
      vectorT      v;
      fd = $fopen("ctrl_golden.txt", "r");
      if (fd == 0) begin
         failRun("cannot open golden file ctrl_golden.txt");
      end
      while ($fgets(line, fd) != 0) begin
         // skip comments and blank lines
         if (line.len() < 2 || line.substr(0, 0) == "#") begin
            continue;
         end
         got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                       col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                       col[15], col[16], col[17], col[18]);
         if (got != 19) begin
            failRun($sformatf("malformed golden line: %s", line));
         end
         v.instr1     = makeInstr(col[0], col[1], col[2], col[3], col[4], col[5]);
         v.instr2     = makeInstr(col[6], col[7], col[8], col[9], col[10], col[11]);
         v.zero1      = col[12][0];
         v.zero2      = col[13][0];
         v.mispredict = col[14][0];
         v.exp1       = expandDigits(col[15]);
         v.exp2       = expandDigits(col[16]);
         v.raw        = col[17][0];
         v.waw        = col[18][0];
         vectors.push_back(v);
      end
      $fclose(fd);
      if (vectors.size() == 0) begin
         failRun("golden file holds no vectors");
      end
      numVectors = vectors.size();
   endtask

   // budget covers reset, every vector and some slack
   initial begin
      wait (numVectors > 0);
      #((numVectors + 16 + 10) * 100);
      failRun("timeout: simulation ran past its time budget");
   end

   initial begin
      reset      = 1'b1;
      instr1D    = '0;
      instr2D    = '0;
      zero1E     = 1'b0;
      zero2E     = 1'b0;
      mispredict = 1'b0;
      loadVectors();
      repeat (16) @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < numVectors; i++) begin
         instr1D    = vectors[i].instr1;
         instr2D    = vectors[i].instr2;
         zero1E     = vectors[i].zero1;
         zero2E     = vectors[i].zero2;
         mispredict = vectors[i].mispredict;
         // sample late in the cycle, before the next rising edge
         #40;
         checkSlot($sformatf("vector %0d slot1", i), vectors[i].exp1, slot1);
         checkSlot($sformatf("vector %0d slot2", i), vectors[i].exp2, slot2);
         checkBit($sformatf("vector %0d raw", i), vectors[i].raw, raw);
         checkBit($sformatf("vector %0d waw", i), vectors[i].waw, waw);
         @(negedge clk);
      end
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: forwardUnit.sv
//////////////////////////////////////////////////
// operand forwarding select for one slot
// own stages first, then the other slot's
//////////////////////////////////////////////////
`default_nettype none

`include "ctrl_defines.svh"

module forwardUnit (
   input  ctrl_pkg::stageRegsT regsE_i,
   input  ctrl_pkg::wbInfoT    ownM_i,
   input  ctrl_pkg::wbInfoT    ownW_i,
   input  ctrl_pkg::wbInfoT    otherM_i,
   input  ctrl_pkg::wbInfoT    otherW_i,
   output ctrl_pkg::fwdSelT    forwardA_o,
   output ctrl_pkg::fwdSelT    forwardB_o
);

   import ctrl_pkg::*;

   // first match wins, x0 always reads the register file
   function automatic fwdSelT pickSource(
      input regAddrT rs,
      input wbInfoT  ownM,
      input wbInfoT  ownW,
      input wbInfoT  otherM,
      input wbInfoT  otherW
   );
      fwdSelT sel;
      sel = '{crossSlot: 1'b0, src: fwdNone};
      if (rs != regAddrT'(`ZERO_REG)) begin
         if (ownM.regWrite && (ownM.rd == rs)) begin
            sel = '{crossSlot: 1'b0, src: fwdMem};
         end else if (ownW.regWrite && (ownW.rd == rs)) begin
            sel = '{crossSlot: 1'b0, src: fwdWb};
         end else if (otherM.regWrite && (otherM.rd == rs)) begin
            sel = '{crossSlot: 1'b1, src: fwdMem};
         end else if (otherW.regWrite && (otherW.rd == rs)) begin
            sel = '{crossSlot: 1'b1, src: fwdWb};
         end
      end
      return sel;
   endfunction

   assign forwardA_o = pickSource(regsE_i.rs1, ownM_i, ownW_i, otherM_i, otherW_i);
   assign forwardB_o = pickSource(regsE_i.rs2, ownM_i, ownW_i, otherM_i, otherW_i);

endmodule

`default_nettype wire

// File: hazardUnit.sv
//////////////////////////////////////////////////
// stall and flush generation for both slots
// load-use and decode pair hazards
//////////////////////////////////////////////////
`default_nettype none

`include "ctrl_defines.svh"

module hazardUnit (
   input  ctrl_pkg::decInstrT  instr1D_i,
   input  ctrl_pkg::decInstrT  instr2D_i,
   input  logic                regWrite1D_i,
   input  logic                regWrite2D_i,
   input  ctrl_pkg::stageRegsT regs1E_i,
   input  ctrl_pkg::stageRegsT regs2E_i,
   input  logic                load1E_i,
   input  logic                load2E_i,
   input  logic                mispredict_i,
   output logic                stall1_o,
   output logic                stall2_o,
   output logic                flushD1_o,
   output logic                flushD2_o,
   output logic                flushE1_o,
   output logic                flushE2_o,
   output logic                raw_o,
   output logic                waw_o
);

   import ctrl_pkg::*;

   logic loadStall1;
   logic loadStall2;
   logic loadCross1;
   logic loadCross2;
   logic rs2Valid2;
   logic pairHazard;

   // true when a load in execute targets one of the decode sources
   function automatic logic loadHit(input logic load, input regAddrT rdE,
                                    input decInstrT instrD);
      return load && (rdE != regAddrT'(`ZERO_REG)) &&
             ((instrD.rs1 == rdE) || (instrD.rs2 == rdE));
   endfunction

   assign loadStall1 = loadHit(load1E_i, regs1E_i.rd, instr1D_i);
   assign loadStall2 = loadHit(load2E_i, regs2E_i.rd, instr2D_i);
   assign loadCross1 = loadHit(load1E_i, regs1E_i.rd, instr2D_i);
   assign loadCross2 = loadHit(load2E_i, regs2E_i.rd, instr1D_i);

   // rs2 is a real source only for these formats
   assign rs2Valid2 = (instr2D_i.op == opRtype) || (instr2D_i.op == opSw) ||
                      (instr2D_i.op == opBranch);

   assign raw_o = regWrite1D_i && (instr1D_i.rd != regAddrT'(`ZERO_REG)) &&
                  ((instr2D_i.rs1 == instr1D_i.rd) ||
                   (rs2Valid2 && (instr2D_i.rs2 == instr1D_i.rd)));

   assign waw_o = regWrite1D_i && regWrite2D_i &&
                  (instr1D_i.rd == instr2D_i.rd) &&
                  (instr1D_i.rd != regAddrT'(`ZERO_REG));

   // any of these squashes the younger instruction in slot 2
   assign pairHazard = raw_o || waw_o || loadCross1 || loadCross2;

   assign stall1_o  = loadStall1;
   assign stall2_o  = loadStall2;
   assign flushD1_o = mispredict_i;
   assign flushE1_o = loadStall1 || mispredict_i;
   assign flushD2_o = pairHazard || mispredict_i;
   assign flushE2_o = pairHazard || mispredict_i;

endmodule

`default_nettype wire

// File: instrDecoder.sv
//////////////////////////////////////////////////
// decode-stage control decoder for one slot
// main decoder table plus ALU-control decoding
//////////////////////////////////////////////////
`default_nettype none

`include "ctrl_defines.svh"

module instrDecoder (
   input  ctrl_pkg::decInstrT instr_i,
   output ctrl_pkg::decCtrlT  ctrl_o
);

   import ctrl_pkg::*;

   // row of the main decoder table
   typedef struct packed {
      logic      regWrite;
      immSrcE    immSrc;
      logic      aluSrc;
      logic      memWrite;
      resultSrcE resultSrc;
      logic      branch;
      aluOpE     aluOp;
      logic      jump;
   } mainDecT;

   mainDecT main;
   aluCtrlE aluControl;
   logic    rtypeSub;

   // unknown opcodes fall into the all-zero row
   always_comb begin
      case (instr_i.op)
         opLw:       main = '{1'b1, immI, 1'b1, 1'b0, resLoad,    1'b0, aluOpMem,    1'b0};
         opSw:       main = '{1'b0, immS, 1'b1, 1'b1, resAlu,     1'b0, aluOpMem,    1'b0};
         opRtype:    main = '{1'b1, immI, 1'b0, 1'b0, resAlu,     1'b0, aluOpOther,  1'b0};
         opBranch:   main = '{1'b0, immB, 1'b0, 1'b0, resAlu,     1'b1, aluOpBranch, 1'b0};
         opItypeAlu: main = '{1'b1, immI, 1'b1, 1'b0, resAlu,     1'b0, aluOpOther,  1'b0};
         opJal:      main = '{1'b1, immJ, 1'b0, 1'b0, resPcPlus4, 1'b0, aluOpMem,    1'b1};
         opLui:      main = '{1'b1, immU, 1'b0, 1'b0, resImm,     1'b0, aluOpMem,    1'b0};
         opJalr:     main = '{1'b1, immI, 1'b1, 1'b0, resPcPlus4, 1'b0, aluOpMem,    1'b1};
         default:    main = '{1'b0, immI, 1'b0, 1'b0, resAlu,     1'b0, aluOpMem,    1'b0};
      endcase
   end

   // only register-register add with funct7[5] means sub
   assign rtypeSub = instr_i.funct7b5 && (instr_i.op == opRtype);

   always_comb begin
      case (main.aluOp)
         aluOpBranch: aluControl = aluSub;
         aluOpOther: begin
            case (instr_i.funct3)
               `F3_ADDSUB: aluControl = rtypeSub ? aluSub : aluAdd;
               `F3_SLT:    aluControl = aluSlt;
               `F3_OR:     aluControl = aluOr;
               `F3_AND:    aluControl = aluAnd;
               default:    aluControl = aluAdd;
            endcase
         end
         default: aluControl = aluAdd;
      endcase
   end

   always_comb begin
      ctrl_o.regWrite   = main.regWrite;
      ctrl_o.immSrc     = main.immSrc;
      ctrl_o.aluSrc     = main.aluSrc;
      ctrl_o.memWrite   = main.memWrite;
      ctrl_o.resultSrc  = main.resultSrc;
      ctrl_o.branch     = main.branch;
      // inverts zero in execute for bne
      ctrl_o.branchNe   = main.branch && (instr_i.funct3 == `F3_BNE);
      ctrl_o.jump       = main.jump;
      ctrl_o.aluControl = aluControl;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
ctrl_pkg.sv
instrDecoder.sv
ctrlPipe.sv
forwardUnit.sv
hazardUnit.sv
dualIssueCtrl.sv
dualIssueCtrl_tb.sv
